//--- gb_map_pkg.sv
`default_nettype none

package gb_map_pkg;

	// Region of a bus address as the fabric routes it
	typedef enum logic [2:0] {
		REG_EXT    = 3'd0, // Cartridge ROM, cartridge RAM, work RAM and its echo
		REG_VRAM   = 3'd1,
		REG_OAM    = 3'd2,
		REG_UNUSED = 3'd3, // Nothing answers here
		REG_IO     = 3'd4,
		REG_DMA    = 3'd5,
		REG_HRAM   = 3'd6
	} region_t;

	// Lower bounds of the address ranges, each range ends below the next one
	localparam logic [15:0] VRAM_BASE   = 16'h8000;
	localparam logic [15:0] XRAM_BASE   = 16'hA000; // External bus again from here
	localparam logic [15:0] OAM_BASE    = 16'hFE00;
	localparam logic [15:0] UNUSED_BASE = 16'hFEA0;
	localparam logic [15:0] IO_BASE     = 16'hFF00;
	localparam logic [15:0] HRAM_BASE   = 16'hFF80;

	// Single registers that stand out of their range
	localparam logic [15:0] DMA_REG     = 16'hFF46;
	localparam logic [15:0] IE_REG      = 16'hFFFF; // Top byte is an I/O register, not HRAM

endpackage

`default_nettype wire

//--- gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] cpu_adr_t;

	// Offsets inside the on-chip memories
	typedef logic [12:0] vram_adr_t; // From 8000
	typedef logic [7:0]  oam_adr_t;  // From FE00
	typedef logic [6:0]  hram_adr_t; // From FF80

	// Value of a data bus that nobody drives
	localparam byte_t OPEN_BUS = 8'hFF;

endpackage

`default_nettype wire

//--- gb_mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gb_mem_decode (
	input  gb_bus_pkg::cpu_adr_t adr,
	output gb_map_pkg::region_t  region
);
	import gb_map_pkg::*;

	// The ranges are compared in ascending order so every address hits exactly one
	always_comb begin
		if (adr == DMA_REG)
			region = REG_DMA;
		else if (adr < VRAM_BASE)
			region = REG_EXT; // Cartridge ROM
		else if (adr < XRAM_BASE)
			region = REG_VRAM;
		else if (adr < OAM_BASE)
			region = REG_EXT; // Cartridge RAM, work RAM and echo
		else if (adr < UNUSED_BASE)
			region = REG_OAM;
		else if (adr < IO_BASE)
			region = REG_UNUSED;
		else if (adr < HRAM_BASE || adr == IE_REG)
			region = REG_IO;
		else
			region = REG_HRAM;
	end

endmodule

`default_nettype wire

//--- gb_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module gb_port_arbiter #(
	parameter type addr_t     = logic [7:0],
	parameter bit  DMA_WRITES = 1'b0
) (
	input  logic                ppu_need,
	input  addr_t               ppu_adr,
	input  logic                dma_req,
	input  addr_t               dma_adr,
	input  gb_bus_pkg::byte_t   dma_wdata,
	input  logic                cpu_sel,
	input  logic                cpu_rd,
	input  logic                cpu_wr,
	input  addr_t               cpu_adr,
	input  gb_bus_pkg::byte_t   cpu_wdata,
	output logic                mem_en,
	output logic                mem_we,
	output addr_t               mem_adr,
	output gb_bus_pkg::byte_t   mem_wdata,
	output logic                cpu_gnt
);

	always_comb begin
		mem_en    = 1'b0;
		mem_we    = 1'b0;
		mem_adr   = cpu_adr;
		mem_wdata = cpu_wdata;
		cpu_gnt   = 1'b0;

		if (ppu_need) begin
			mem_en  = 1'b1; // PPU only ever reads
			mem_adr = ppu_adr;
		end else if (dma_req) begin
			mem_en  = 1'b1;
			mem_adr = dma_adr;
			if (DMA_WRITES) begin
				mem_we    = 1'b1; // OAM side is the copy target
				mem_wdata = dma_wdata;
			end
		end else if (cpu_sel && (cpu_rd || cpu_wr)) begin
			mem_en  = 1'b1;
			mem_we  = cpu_wr;
			cpu_gnt = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- gb_sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gb_sync_ram #(
	parameter int DEPTH     = 256,
	parameter int ADDR_BITS = 8
) (
	input  logic                 gbclk,
	input  logic                 en,
	input  logic                 we,
	input  logic [ADDR_BITS-1:0] adr,
	input  gb_bus_pkg::byte_t    wdata,
	output gb_bus_pkg::byte_t    rdata
);
	import gb_bus_pkg::*;

	byte_t mem [DEPTH];

	// Read data stays put until the next read, a write leaves it alone
	always_ff @(posedge gbclk) begin
		if (en) begin
			if (we)
				mem[adr] <= wdata;
			else
				rdata <= mem[adr];
		end
	end

endmodule

`default_nettype wire

//--- gb_oam_dma.sv
`timescale 1ns/1ps
`default_nettype none

module gb_oam_dma #(
	parameter int DMA_LEN = 160
) (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  gb_map_pkg::region_t  cpu_region,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,
	input  gb_bus_pkg::cpu_adr_t cpu_adr,
	input  gb_bus_pkg::byte_t    cpu_wdata,
	input  gb_map_pkg::region_t  src_region,
	input  gb_bus_pkg::byte_t    src_rdata,
	input  gb_bus_pkg::byte_t    ext_rdata,
	output gb_bus_pkg::byte_t    dma_page,
	output gb_bus_pkg::cpu_adr_t src_adr,
	output logic                 vram_req,
	output logic                 oam_req,
	output gb_bus_pkg::oam_adr_t oam_adr,
	output gb_bus_pkg::byte_t    oam_wdata,
	output logic                 dma_active,
	output gb_bus_pkg::cpu_adr_t ext_adr,
	output logic                 ext_rd,
	output logic                 ext_wr,
	output gb_bus_pkg::byte_t    ext_wdata,
	output logic                 cpu_ext_gnt
);
	import gb_bus_pkg::*;
	import gb_map_pkg::*;

	byte_t    src_page; // Page of the running copy
	oam_adr_t rd_cnt;
	logic     rd_busy;
	logic     wr_busy;
	logic     reg_wr;
	logic     start;
	logic     dma_ext;
	logic     cpu_ext;

	assign reg_wr = cpu_wr && cpu_region == REG_DMA;
	assign start  = reg_wr && !dma_active; // A copy in flight is never restarted

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			dma_page <= 8'h00;
			rd_busy  <= 1'b0;
			wr_busy  <= 1'b0;
			rd_cnt   <= '0;
		end else begin
			wr_busy <= rd_busy;
			if (reg_wr)
				dma_page <= cpu_wdata;
			if (start) begin
				rd_busy <= 1'b1;
				rd_cnt  <= '0;
			end else if (rd_busy) begin
				if (rd_cnt == oam_adr_t'(DMA_LEN - 1)) begin
					rd_busy <= 1'b0;
					rd_cnt  <= '0; // Idle counter points at OAM byte 0
				end else begin
					rd_cnt <= rd_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge gbclk) begin
		oam_adr <= rd_cnt; // Write stage trails the read stage by one cycle
		if (start)
			src_page <= cpu_wdata;
	end

	assign src_adr    = {src_page, rd_cnt};
	assign dma_active = rd_busy || wr_busy;
	assign vram_req   = rd_busy && src_region == REG_VRAM;
	assign oam_req    = dma_active;
	assign oam_wdata  = src_rdata;

	// External bus goes to the DMA only while it reads from there
	assign dma_ext     = rd_busy && src_region == REG_EXT;
	assign cpu_ext     = cpu_region == REG_EXT && !dma_ext;
	assign cpu_ext_gnt = cpu_ext && (cpu_rd || cpu_wr);

	assign ext_adr   = dma_ext ? src_adr : cpu_adr;
	assign ext_rd    = dma_ext || (cpu_ext && cpu_rd);
	assign ext_wr    = cpu_ext && cpu_wr;
	assign ext_wdata = dma_ext ? ext_rdata : cpu_wdata; // Data lines keep the bus value

endmodule

`default_nettype wire

//--- gb_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module gb_read_mux (
	input  logic                gbclk,
	input  logic                rst_n,
	input  gb_map_pkg::region_t cpu_region,
	input  logic                cpu_rd,
	input  logic                vram_gnt,
	input  logic                oam_gnt,
	input  logic                cpu_ext_gnt,
	input  logic                dma_active,
	input  gb_map_pkg::region_t src_region,
	input  gb_bus_pkg::byte_t   vram_rdata,
	input  gb_bus_pkg::byte_t   oam_rdata,
	input  gb_bus_pkg::byte_t   hram_rdata,
	input  gb_bus_pkg::byte_t   ext_rdata,
	input  gb_bus_pkg::byte_t   dma_page,
	output gb_bus_pkg::byte_t   cpu_rdata,
	output gb_bus_pkg::byte_t   src_rdata
);
	import gb_bus_pkg::*;
	import gb_map_pkg::*;

	logic    rd_q;
	logic    src_vld_q;
	region_t region_q;
	region_t src_region_q;
	logic    vram_gnt_q;
	logic    oam_gnt_q;
	logic    ext_gnt_q;
	byte_t   ext_q;
	byte_t   hold_q;
	byte_t   rd_sel;

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			rd_q      <= 1'b0;
			src_vld_q <= 1'b0;
		end else begin
			rd_q      <= cpu_rd;
			src_vld_q <= dma_active;
		end
	end

	always_ff @(posedge gbclk) begin
		region_q     <= cpu_region;
		src_region_q <= src_region;
		vram_gnt_q   <= vram_gnt;
		oam_gnt_q    <= oam_gnt;
		ext_gnt_q    <= cpu_ext_gnt;
		ext_q        <= ext_rdata; // External memory answers in the request cycle
		if (rd_q)
			hold_q <= rd_sel;
	end

	always_comb begin
		case (region_q)
			REG_VRAM: rd_sel = vram_gnt_q ? vram_rdata : OPEN_BUS;
			REG_OAM:  rd_sel = oam_gnt_q ? oam_rdata : OPEN_BUS;
			REG_EXT:  rd_sel = ext_gnt_q ? ext_q : OPEN_BUS;
			REG_HRAM: rd_sel = hram_rdata;
			REG_DMA:  rd_sel = dma_page;
			default:  rd_sel = OPEN_BUS;
		endcase
	end

	assign cpu_rdata = rd_q ? rd_sel : hold_q;

	// Sources other than VRAM and the external bus copy as open bus
	always_comb begin
		src_rdata = OPEN_BUS;
		if (src_vld_q && src_region_q == REG_VRAM)
			src_rdata = vram_rdata;
		else if (src_vld_q && src_region_q == REG_EXT)
			src_rdata = ext_q;
	end

endmodule

`default_nettype wire

//--- gb_bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus_fabric #(
	parameter int DMA_LEN = 160
) (
	input  logic                  gbclk,
	input  logic                  rst_n,
	input  gb_bus_pkg::cpu_adr_t  cpu_adr,
	input  logic                  cpu_rd,
	input  logic                  cpu_wr,
	input  gb_bus_pkg::byte_t     cpu_wdata,
	output gb_bus_pkg::byte_t     cpu_rdata,
	input  logic                  ppu_needs_vram,
	input  logic                  ppu_needs_oam,
	input  gb_bus_pkg::vram_adr_t ppu_vram_adr,
	input  gb_bus_pkg::oam_adr_t  ppu_oam_adr,
	output gb_bus_pkg::byte_t     ppu_vram_data,
	output gb_bus_pkg::byte_t     ppu_oam_data,
	output gb_bus_pkg::cpu_adr_t  ext_adr,
	output logic                  ext_rd,
	output logic                  ext_wr,
	output gb_bus_pkg::byte_t     ext_wdata,
	input  gb_bus_pkg::byte_t     ext_rdata,
	output logic                  dma_active
);
	import gb_bus_pkg::*;
	import gb_map_pkg::*;

	region_t   cpu_region;
	region_t   src_region;
	cpu_adr_t  src_adr;
	byte_t     dma_page;
	byte_t     src_rdata;
	byte_t     hram_rdata;
	logic      cpu_ext_gnt;
	logic      vram_req;
	logic      oam_req;
	oam_adr_t  dma_oam_adr;
	byte_t     dma_oam_wdata;
	logic      vram_en;
	logic      vram_we;
	vram_adr_t vram_adr;
	byte_t     vram_wdata;
	logic      vram_gnt;
	logic      oam_en;
	logic      oam_we;
	oam_adr_t  oam_adr;
	byte_t     oam_wdata;
	logic      oam_gnt;

	gb_mem_decode cpu_decode (.adr(cpu_adr), .region(cpu_region));
	gb_mem_decode dma_decode (.adr(src_adr), .region(src_region));

	gb_port_arbiter #(.addr_t(vram_adr_t), .DMA_WRITES(1'b0)) vram_arb (
		.ppu_need(ppu_needs_vram), .ppu_adr(ppu_vram_adr),
		.dma_req(vram_req), .dma_adr(vram_adr_t'(src_adr)), .dma_wdata(dma_oam_wdata),
		.cpu_sel(cpu_region == REG_VRAM), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.cpu_adr(vram_adr_t'(cpu_adr)), .cpu_wdata(cpu_wdata),
		.mem_en(vram_en), .mem_we(vram_we), .mem_adr(vram_adr), .mem_wdata(vram_wdata),
		.cpu_gnt(vram_gnt)
	);

	gb_port_arbiter #(.addr_t(oam_adr_t), .DMA_WRITES(1'b1)) oam_arb (
		.ppu_need(ppu_needs_oam), .ppu_adr(ppu_oam_adr),
		.dma_req(oam_req), .dma_adr(dma_oam_adr), .dma_wdata(dma_oam_wdata),
		.cpu_sel(cpu_region == REG_OAM), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.cpu_adr(oam_adr_t'(cpu_adr)), .cpu_wdata(cpu_wdata),
		.mem_en(oam_en), .mem_we(oam_we), .mem_adr(oam_adr), .mem_wdata(oam_wdata),
		.cpu_gnt(oam_gnt)
	);

	gb_sync_ram #(.DEPTH(2 ** $bits(vram_adr_t)), .ADDR_BITS($bits(vram_adr_t))) vram_mem (
		.gbclk(gbclk), .en(vram_en), .we(vram_we), .adr(vram_adr),
		.wdata(vram_wdata), .rdata(ppu_vram_data)
	);

	gb_sync_ram #(.DEPTH(DMA_LEN), .ADDR_BITS($bits(oam_adr_t))) oam_mem (
		.gbclk(gbclk), .en(oam_en), .we(oam_we), .adr(oam_adr),
		.wdata(oam_wdata), .rdata(ppu_oam_data)
	);

	// HRAM is the CPU's alone, FFFF belongs to the I/O space
	gb_sync_ram #(.DEPTH(127), .ADDR_BITS($bits(hram_adr_t))) hram_mem (
		.gbclk(gbclk), .en(cpu_region == REG_HRAM && (cpu_rd || cpu_wr)), .we(cpu_wr),
		.adr(hram_adr_t'(cpu_adr)), .wdata(cpu_wdata), .rdata(hram_rdata)
	);

	gb_oam_dma #(.DMA_LEN(DMA_LEN)) dma (
		.gbclk(gbclk), .rst_n(rst_n),
		.cpu_region(cpu_region), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.cpu_adr(cpu_adr), .cpu_wdata(cpu_wdata),
		.src_region(src_region), .src_rdata(src_rdata), .ext_rdata(ext_rdata),
		.dma_page(dma_page), .src_adr(src_adr), .vram_req(vram_req), .oam_req(oam_req),
		.oam_adr(dma_oam_adr), .oam_wdata(dma_oam_wdata), .dma_active(dma_active),
		.ext_adr(ext_adr), .ext_rd(ext_rd), .ext_wr(ext_wr), .ext_wdata(ext_wdata),
		.cpu_ext_gnt(cpu_ext_gnt)
	);

	gb_read_mux rmux (
		.gbclk(gbclk), .rst_n(rst_n),
		.cpu_region(cpu_region), .cpu_rd(cpu_rd),
		.vram_gnt(vram_gnt), .oam_gnt(oam_gnt), .cpu_ext_gnt(cpu_ext_gnt),
		.dma_active(dma_active), .src_region(src_region),
		.vram_rdata(ppu_vram_data), .oam_rdata(ppu_oam_data), .hram_rdata(hram_rdata),
		.ext_rdata(ext_rdata), .dma_page(dma_page),
		.cpu_rdata(cpu_rdata), .src_rdata(src_rdata)
	);

endmodule

`default_nettype wire

//--- gb_bus_fabric_props.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus_fabric_props #(
	parameter int DMA_LEN = 160
) (
	input logic gbclk,
	input logic rst_n,
	input logic ppu_needs_vram,
	input logic ppu_needs_oam,
	input logic vram_we,
	input logic oam_we,
	input logic ext_rd,
	input logic ext_wr,
	input logic dma_active
);
	int active_cnt;

	always_ff @(posedge gbclk) begin
		if (!rst_n)
			active_cnt <= 0;
		else
			active_cnt <= dma_active ? active_cnt + 1 : 0;
	end

	vram_claim: assert property (@(posedge gbclk) disable iff (!rst_n)
		ppu_needs_vram |-> !vram_we) else $error("Write reached claimed VRAM");
	oam_claim: assert property (@(posedge gbclk) disable iff (!rst_n)
		ppu_needs_oam |-> !oam_we) else $error("Write reached claimed OAM");
	ext_excl: assert property (@(posedge gbclk) disable iff (!rst_n)
		!(ext_rd && ext_wr)) else $error("External read and write together");
	dma_max: assert property (@(posedge gbclk) disable iff (!rst_n)
		dma_active |-> active_cnt < DMA_LEN + 1) else $error("DMA ran too long");
	dma_len: assert property (@(posedge gbclk) disable iff (!rst_n)
		(!dma_active && active_cnt != 0) |-> active_cnt == DMA_LEN + 1)
		else $error("DMA ended early");

endmodule

bind gb_bus_fabric gb_bus_fabric_props #(.DMA_LEN(DMA_LEN)) props (
	.gbclk(gbclk), .rst_n(rst_n),
	.ppu_needs_vram(ppu_needs_vram), .ppu_needs_oam(ppu_needs_oam),
	.vram_we(vram_we), .oam_we(oam_we),
	.ext_rd(ext_rd), .ext_wr(ext_wr), .dma_active(dma_active)
);

`default_nettype wire

//--- gb_bus_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gb_bus_fabric_tb;
	localparam int DMA_LEN = 160;
	localparam int BUDGET = 10 + 40 + (DMA_LEN + 40) + 40
		+ (3 * DMA_LEN + 40) + (5 * DMA_LEN + 40);

	logic gbclk, rst_n, cpu_rd, cpu_wr, ppu_needs_vram, ppu_needs_oam, ext_rd, ext_wr, dma_active;
	logic [15:0] cpu_adr, ext_adr;
	logic [12:0] ppu_vram_adr;
	logic [7:0] cpu_wdata, cpu_rdata, ppu_oam_adr, ppu_vram_data, ppu_oam_data;
	logic [7:0] ext_wdata, ext_rdata;
	logic [7:0] ext_mem [65536];
	logic [7:0] expect_oam [DMA_LEN];
	logic [31:0] seed;
	int errors, checks, tests, active_cycles;

	gb_bus_fabric #(.DMA_LEN(DMA_LEN)) uut (.*);

	always #50 gbclk = ~gbclk;

	assign ext_rdata = ext_mem[ext_adr]; // Memory model answers without a clock

	always @(posedge gbclk) begin
		if (ext_wr)
			ext_mem[ext_adr] <= ext_wdata;
	end

	always @(negedge gbclk) begin
		if (dma_active)
			active_cycles++;
	end

	initial begin
		#(BUDGET * 2 * 100);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	function automatic logic [7:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed[23:16];
	endfunction

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic cpu_write(input logic [15:0] adr, input logic [7:0] data);
		@(negedge gbclk);
		cpu_adr = adr;
		cpu_wdata = data;
		cpu_wr = 1'b1;
		@(negedge gbclk);
		cpu_wr = 1'b0;
	endtask

	// Data is sampled one cycle after the request cycle
	task automatic cpu_read(input logic [15:0] adr, output logic [7:0] data);
		@(negedge gbclk);
		cpu_adr = adr;
		cpu_rd = 1'b1;
		@(negedge gbclk);
		cpu_rd = 1'b0;
		data = cpu_rdata;
	endtask

	task automatic wait_dma_done();
		int n;
		n = 0;
		while (dma_active && n < 4 * DMA_LEN) begin
			@(negedge gbclk);
			n++;
		end
		if (dma_active) begin
			errors++;
			$display("DMA copy did not finish within %0d cycles", 4 * DMA_LEN);
		end
	endtask

	task automatic report(input string name, input int err_before);
		tests++;
		$display("%s: %s", name, errors == err_before ? "ok" : "failed");
	endtask

	task automatic round_trip();
		logic [15:0] adrs [8] = '{16'h0123, 16'hA010, 16'hC003, 16'h8000, 16'h9FFF,
			16'hFE10, 16'hFF80, 16'hFFFE};
		logic [7:0] vals [8];
		logic [7:0] d;
		int e;
		e = errors;
		foreach (adrs[i]) begin
			vals[i] = next_rand();
			cpu_write(adrs[i], vals[i]);
		end
		foreach (adrs[i]) begin
			cpu_read(adrs[i], d);
			check("cpu_rdata", d, vals[i]);
		end
		for (int i = 0; i < 3; i++)
			check("ext_mem", ext_mem[adrs[i]], vals[i]);
		report("round trip", e);
	endtask

	task automatic unmapped_regions();
		logic [7:0] d, h;
		int e;
		e = errors;
		h = next_rand();
		cpu_write(16'hFF90, h); // Same HRAM offset as FF10
		cpu_read(16'hFF46, d);
		check("dma_reg", d, 8'h00);
		cpu_write(16'hFEA5, 8'h11);
		cpu_write(16'hFF10, ~h);
		cpu_write(16'hFFFF, 8'h33); // Must not land in HRAM
		cpu_read(16'hFEA5, d);
		check("cpu_rdata", d, 8'hFF);
		cpu_read(16'hFF10, d);
		check("cpu_rdata", d, 8'hFF);
		cpu_read(16'hFFFF, d);
		check("cpu_rdata", d, 8'hFF);
		cpu_read(16'hFF90, d);
		check("cpu_rdata", d, h);
		cpu_write(16'hFF46, 8'hD0);
		cpu_read(16'hFF46, d);
		check("dma_reg", d, 8'hD0);
		wait_dma_done();
		report("unmapped and registers", e);
	endtask

	task automatic ppu_claim();
		logic [7:0] d, old, nxt, oam_old;
		int e;
		e = errors;
		old = next_rand();
		nxt = next_rand();
		oam_old = next_rand();
		cpu_write(16'h8123, old);
		cpu_write(16'h8124, nxt);
		cpu_write(16'hFE42, oam_old);
		@(negedge gbclk);
		ppu_needs_vram = 1'b1;
		ppu_vram_adr = 13'h0123;
		ppu_needs_oam = 1'b1;
		ppu_oam_adr = 8'h42;
		@(negedge gbclk);
		check("ppu_vram_data", ppu_vram_data, old);
		check("ppu_oam_data", ppu_oam_data, oam_old);
		ppu_vram_adr = 13'h0124;
		@(negedge gbclk);
		check("ppu_vram_data", ppu_vram_data, nxt);
		cpu_read(16'h8123, d);
		check("cpu_rdata", d, 8'hFF);
		cpu_read(16'hFE42, d);
		check("cpu_rdata", d, 8'hFF);
		cpu_write(16'h8123, ~old);
		cpu_write(16'hFE42, ~oam_old);
		@(negedge gbclk);
		ppu_needs_vram = 1'b0;
		ppu_needs_oam = 1'b0;
		cpu_read(16'h8123, d);
		check("cpu_rdata", d, old);
		cpu_read(16'hFE42, d);
		check("cpu_rdata", d, oam_old);
		report("ppu claim", e);
	endtask

	task automatic ext_page_dma();
		logic [7:0] d, v;
		int e;
		e = errors;
		active_cycles = 0;
		cpu_write(16'hFF46, 8'hC1);
		// First source read goes out in the cycle after the register write
		check("dma_active", dma_active, 1'b1);
		check("ext_rd", ext_rd, 1'b1);
		check("ext_adr", ext_adr, 16'hC100);
		cpu_read(16'hFE05, d);
		check("cpu_rdata", d, 8'hFF);
		cpu_read(16'hC000, d);
		check("cpu_rdata", d, 8'hFF);
		v = next_rand();
		cpu_write(16'hFF90, v);
		cpu_read(16'hFF90, d);
		check("cpu_rdata", d, v);
		wait_dma_done();
		check("dma_active cycles", active_cycles, DMA_LEN + 1);
		for (int k = 0; k < DMA_LEN; k++) begin
			cpu_read(16'hFE00 + k, d);
			check("oam", d, ext_mem[16'hC100 + k]);
		end
		report("dma from external", e);
	endtask

	task automatic vram_page_dma();
		logic [7:0] d, v;
		int e;
		e = errors;
		for (int k = 0; k < DMA_LEN; k++) begin
			expect_oam[k] = next_rand();
			cpu_write(16'h8000 + k, expect_oam[k]);
		end
		cpu_write(16'hFF46, 8'h80);
		check("ext_rd", ext_rd, 1'b0);
		v = next_rand();
		cpu_write(16'hC050, v); // External bus stays with the CPU
		cpu_read(16'hC050, d);
		check("cpu_rdata", d, v);
		check("ext_mem", ext_mem[16'hC050], v);
		wait_dma_done();
		for (int k = 0; k < DMA_LEN; k++) begin
			cpu_read(16'hFE00 + k, d);
			check("oam", d, expect_oam[k]);
		end
		report("dma from vram", e);
	endtask

	initial begin
		gbclk = 1'b0;
		rst_n = 1'b0;
		{cpu_rd, cpu_wr, ppu_needs_vram, ppu_needs_oam} = '0;
		cpu_adr = '0;
		cpu_wdata = '0;
		ppu_vram_adr = '0;
		ppu_oam_adr = '0;
		seed = 32'd31936;
		for (int a = 0; a < 65536; a++)
			ext_mem[a] = a[7:0] ^ a[15:8] ^ 8'h5A;
		repeat (3) @(posedge gbclk);
		@(negedge gbclk);
		rst_n = 1'b1;
		round_trip();
		unmapped_regions();
		ppu_claim();
		ext_page_dma();
		vram_page_dma();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
gb_map_pkg.sv
gb_bus_pkg.sv
gb_mem_decode.sv
gb_port_arbiter.sv
gb_sync_ram.sv
gb_oam_dma.sv
gb_read_mux.sv
gb_bus_fabric.sv
gb_bus_fabric_props.sv
gb_bus_fabric_tb.sv

//--- Makefile
TOP = gb_bus_fabric_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f src.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
